/* design/texture_pkg.sv */
package texture_pkg;

  // ring size for the 3x3 neighbourhood
  localparam int NUM_NEIGHBOURS = 8;

  // ring code meaning more than two transitions
  localparam logic [3:0] RING_NON_UNIFORM = 4'd9;

  typedef logic [7:0] pixel_t;

  // ring[0] is top-left, then clockwise
  typedef struct packed {
    pixel_t                           centre;
    pixel_t [NUM_NEIGHBOURS-1:0]      ring;
  } window_t;

  // 0 to 8 ones for uniform patterns, 9 otherwise
  typedef logic [3:0] ring_code_t;

endpackage

/* design/hist_pkg.sv */
package hist_pkg;

  // two centre classes times ten ring codes
  localparam int NUM_BINS = 20;

  typedef logic [4:0]  bin_idx_t;
  typedef logic [15:0] count_t;

  typedef struct packed {
    logic     valid;
    bin_idx_t idx;
  } desc_t;

  // readout sequencing
  typedef enum logic [1:0] {
    ACCUM,
    FULL,
    READ,
    DONE
  } hist_state_e;

endpackage

/* design/pixel_window.sv */
module pixel_window #(
  parameter int COLS = 8,
  parameter int ROWS = 6
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  texture_pkg::pixel_t  pixel_i,
  input  logic                 pixel_valid_i,
  output texture_pkg::window_t win_o,
  output logic                 win_valid_o
);

  localparam int CW = $clog2(COLS);
  localparam int RW = $clog2(ROWS);

  logic [CW-1:0] col_q;
  logic [RW-1:0] row_q;

  // line0 holds the previous row, line1 the one above it
  texture_pkg::pixel_t line0_q [COLS];
  texture_pkg::pixel_t line1_q [COLS];

  // 3x3 shift window, index 2 is the newest column
  texture_pkg::pixel_t [2:0] top_q;
  texture_pkg::pixel_t [2:0] mid_q;
  texture_pkg::pixel_t [2:0] bot_q;

  // raster position of the incoming pixel
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_q       <= '0;
      row_q       <= '0;
      win_valid_o <= 1'b0;
    end else begin
      win_valid_o <= pixel_valid_i && (col_q >= CW'(2)) && (row_q >= RW'(2));
      if (pixel_valid_i) begin
        if (col_q == CW'(COLS - 1)) begin
          col_q <= '0;
          // wrap at frame end so the next frame starts aligned
          row_q <= (row_q == RW'(ROWS - 1)) ? '0 : row_q + 1'b1;
        end else begin
          col_q <= col_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pixel_valid_i) begin
      line1_q[col_q] <= line0_q[col_q];
      line0_q[col_q] <= pixel_i;
      top_q          <= {line1_q[col_q], top_q[2:1]};
      mid_q          <= {line0_q[col_q], mid_q[2:1]};
      bot_q          <= {pixel_i, bot_q[2:1]};
    end
  end

  // centre sits one row up and one column left of the newest pixel
  always_comb begin
    win_o.centre  = mid_q[1];
    win_o.ring[0] = top_q[0];
    win_o.ring[1] = top_q[1];
    win_o.ring[2] = top_q[2];
    win_o.ring[3] = mid_q[2];
    win_o.ring[4] = bot_q[2];
    win_o.ring[5] = bot_q[1];
    win_o.ring[6] = bot_q[0];
    win_o.ring[7] = mid_q[0];
  end

endmodule

/* design/riu2_encoder.sv */
module riu2_encoder (
  input  logic                 clk,
  input  logic                 rst_n,
  input  texture_pkg::window_t win_i,
  input  logic                 win_valid_i,
  output hist_pkg::desc_t      desc_o
);

  typedef struct packed {
    logic                                  valid;
    logic                                  ci;
    logic [texture_pkg::NUM_NEIGHBOURS-1:0] bits;
  } thresh_t;

  logic [10:0]         sum;
  texture_pkg::pixel_t mean;
  thresh_t             thresh_d;
  thresh_t             thresh_q;

  logic [3:0]              ones;
  logic [3:0]              trans;
  texture_pkg::ring_code_t code;
  hist_pkg::bin_idx_t      idx;

  // stage 1: neighbour mean and threshold bits
  always_comb begin
    sum = '0;
    for (int k = 0; k < texture_pkg::NUM_NEIGHBOURS; k++) begin
      sum = sum + 11'(win_i.ring[k]);
    end
    mean           = sum[10:3];
    thresh_d.valid = win_valid_i;
    thresh_d.ci    = (win_i.centre >= mean);
    for (int k = 0; k < texture_pkg::NUM_NEIGHBOURS; k++) begin
      thresh_d.bits[k] = (win_i.ring[k] >= mean);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      thresh_q.valid <= 1'b0;
    end else begin
      thresh_q.valid <= thresh_d.valid;
    end
  end

  always_ff @(posedge clk) begin
    thresh_q.ci   <= thresh_d.ci;
    thresh_q.bits <= thresh_d.bits;
  end

  // stage 2: circular transitions and ones count
  always_comb begin
    ones  = '0;
    trans = '0;
    for (int k = 0; k < texture_pkg::NUM_NEIGHBOURS; k++) begin
      ones  = ones + 4'(thresh_q.bits[k]);
      trans = trans + 4'(thresh_q.bits[k] ^
                         thresh_q.bits[(k + 1) % texture_pkg::NUM_NEIGHBOURS]);
    end
    code = (trans <= 4'd2) ? ones : texture_pkg::RING_NON_UNIFORM;
    // bright centres land in the upper ten bins
    idx  = hist_pkg::bin_idx_t'(code) + (thresh_q.ci ? 5'd10 : 5'd0);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      desc_o.valid <= 1'b0;
    end else begin
      desc_o.valid <= thresh_q.valid;
    end
  end

  always_ff @(posedge clk) begin
    desc_o.idx <= idx;
  end

endmodule

/* design/joint_histogram.sv */
module joint_histogram #(
  parameter int COLS = 8,
  parameter int ROWS = 6
) (
  input  logic            clk,
  input  logic            rst_n,
  input  hist_pkg::desc_t desc_i,
  input  logic            read_en_i,
  output hist_pkg::count_t bin_o,
  output logic            bin_valid_o,
  output logic            frame_done_o,
  output logic            read_done_o
);

  // descriptors per frame, interior pixels only
  localparam int INTERIOR = (ROWS - 2) * (COLS - 2);

  hist_pkg::count_t      bins_q [hist_pkg::NUM_BINS];
  hist_pkg::count_t      desc_cnt_q;
  hist_pkg::bin_idx_t    rd_idx_q;
  hist_pkg::hist_state_e state_q;

  logic accept;
  logic emit;

  assign accept = desc_i.valid && (state_q == hist_pkg::ACCUM);
  assign emit   = read_en_i &&
                  ((state_q == hist_pkg::FULL) || (state_q == hist_pkg::READ));

  // bin counters, single-cycle increment so repeats to one bin all count
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int b = 0; b < hist_pkg::NUM_BINS; b++) begin
        bins_q[b] <= '0;
      end
    end else if (accept) begin
      bins_q[desc_i.idx] <= bins_q[desc_i.idx] + 1'b1;
    end else if (emit) begin
      // clear on read
      bins_q[rd_idx_q] <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (emit) begin
      bin_o <= bins_q[rd_idx_q];
    end
  end

  // frame and readout sequencing
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q      <= hist_pkg::ACCUM;
      desc_cnt_q   <= '0;
      rd_idx_q     <= '0;
      bin_valid_o  <= 1'b0;
      frame_done_o <= 1'b0;
      read_done_o  <= 1'b0;
    end else begin
      bin_valid_o  <= 1'b0;
      frame_done_o <= 1'b0;
      read_done_o  <= 1'b0;
      case (state_q)
        hist_pkg::ACCUM: begin
          if (accept) begin
            if (desc_cnt_q == hist_pkg::count_t'(INTERIOR - 1)) begin
              desc_cnt_q   <= '0;
              frame_done_o <= 1'b1;
              state_q      <= hist_pkg::FULL;
            end else begin
              desc_cnt_q <= desc_cnt_q + 1'b1;
            end
          end
        end
        hist_pkg::FULL, hist_pkg::READ: begin
          // read_en_i low simply pauses here
          if (emit) begin
            bin_valid_o <= 1'b1;
            if (rd_idx_q == hist_pkg::bin_idx_t'(hist_pkg::NUM_BINS - 1)) begin
              rd_idx_q <= '0;
              state_q  <= hist_pkg::DONE;
            end else begin
              rd_idx_q <= rd_idx_q + 1'b1;
              state_q  <= hist_pkg::READ;
            end
          end
        end
        hist_pkg::DONE: begin
          read_done_o <= 1'b1;
          state_q     <= hist_pkg::ACCUM;
        end
        default: begin
          state_q <= hist_pkg::ACCUM;
        end
      endcase
    end
  end

endmodule

/* design/texture_datapath.sv */
module texture_datapath #(
  parameter int COLS = 8,
  parameter int ROWS = 6
) (
  input  logic                clk,
  input  logic                rst_n,
  input  texture_pkg::pixel_t pixel_i,
  input  logic                pixel_valid_i,
  input  logic                read_en_i,
  output hist_pkg::count_t    bin_o,
  output logic                bin_valid_o,
  output logic                frame_done_o,
  output logic                read_done_o
);

  texture_pkg::window_t win;
  logic                 win_valid;
  hist_pkg::desc_t      desc;

  pixel_window #(
    .COLS(COLS),
    .ROWS(ROWS)
  ) i_pixel_window (
    .clk          (clk),
    .rst_n        (rst_n),
    .pixel_i      (pixel_i),
    .pixel_valid_i(pixel_valid_i),
    .win_o        (win),
    .win_valid_o  (win_valid)
  );

  riu2_encoder i_riu2_encoder (
    .clk        (clk),
    .rst_n      (rst_n),
    .win_i      (win),
    .win_valid_i(win_valid),
    .desc_o     (desc)
  );

  joint_histogram #(
    .COLS(COLS),
    .ROWS(ROWS)
  ) i_joint_histogram (
    .clk         (clk),
    .rst_n       (rst_n),
    .desc_i      (desc),
    .read_en_i   (read_en_i),
    .bin_o       (bin_o),
    .bin_valid_o (bin_valid_o),
    .frame_done_o(frame_done_o),
    .read_done_o (read_done_o)
  );

endmodule

/* verification/tb_model.svh */
// one stored frame and the bins that it should produce
int frame_px [ROWS][COLS];
int exp_bins [hist_pkg::NUM_BINS];

// joint bin of the interior pixel at row r, column c
function automatic int bin_of(input int r, input int c);
  // ring offsets, clockwise from top-left
  int dr [8] = '{-1, -1, -1, 0, 1, 1, 1, 0};
  int dc [8] = '{-1, 0, 1, 1, 1, 0, -1, -1};
  int bits [8];
  int sum;
  int mean;
  int ones;
  int trans;
  sum = 0;
  for (int k = 0; k < 8; k++) begin
    sum += frame_px[r + dr[k]][c + dc[k]];
  end
  mean = sum / 8;
  for (int k = 0; k < 8; k++) begin
    bits[k] = (frame_px[r + dr[k]][c + dc[k]] >= mean) ? 1 : 0;
  end
  ones  = 0;
  trans = 0;
  // ring wraps from neighbour 7 back to neighbour 0
  for (int k = 0; k < 8; k++) begin
    ones  += bits[k];
    trans += (bits[k] != bits[(k + 1) % 8]) ? 1 : 0;
  end
  return ((frame_px[r][c] >= mean) ? 10 : 0) + ((trans <= 2) ? ones : 9);
endfunction

// expected histogram over all interior centres
function automatic void build_expected();
  for (int b = 0; b < hist_pkg::NUM_BINS; b++) begin
    exp_bins[b] = 0;
  end
  for (int r = 1; r < ROWS - 1; r++) begin
    for (int c = 1; c < COLS - 1; c++) begin
      exp_bins[bin_of(r, c)]++;
    end
  end
endfunction

/* verification/tb_texture_datapath.sv */
module tb_texture_datapath;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int COLS    = 8;
  localparam int ROWS    = 6;
  localparam int TIMEOUT = 1000;

  logic                clk;
  logic                rst_n;
  texture_pkg::pixel_t pixel;
  logic                pixel_valid;
  logic                read_en;
  hist_pkg::count_t    bin;
  logic                bin_valid;
  logic                frame_done;
  logic                read_done;

  int errors;
  int tests_pass;
  int tests_fail;
  int frame_done_cnt;
  int read_done_cnt;

  `include "tb_model.svh"

  texture_datapath #(
    .COLS(COLS),
    .ROWS(ROWS)
  ) i_texture_datapath (
    .clk          (clk),
    .rst_n        (rst_n),
    .pixel_i      (pixel),
    .pixel_valid_i(pixel_valid),
    .read_en_i    (read_en),
    .bin_o        (bin),
    .bin_valid_o  (bin_valid),
    .frame_done_o (frame_done),
    .read_done_o  (read_done)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // pulse counters sampled on the rising edge
  always @(posedge clk) begin
    if (frame_done === 1'b1) begin
      frame_done_cnt++;
    end
    if (read_done === 1'b1) begin
      read_done_cnt++;
    end
  end

  task automatic check_value(input string name, input int expected, input logic [31:0] actual);
    assert (actual === 32'(expected)) else begin
      $display("Fail at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic fill_frame(input bit flat);
    int level;
    level = $urandom_range(255);
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        frame_px[r][c] = flat ? level : $urandom_range(255);
      end
    end
  endtask

  // raster order with optional idle cycles between strobes
  task automatic send_frame(input bit gaps);
    int idle;
    for (int i = 0; i < ROWS * COLS; i++) begin
      idle = gaps ? $urandom_range(3) : 0;
      repeat (idle) begin
        @(posedge clk);
        #1;
        pixel_valid = 1'b0;
      end
      @(posedge clk);
      #1;
      pixel       = texture_pkg::pixel_t'(frame_px[i / COLS][i % COLS]);
      pixel_valid = 1'b1;
    end
    @(posedge clk);
    #1;
    pixel_valid = 1'b0;
  endtask

  task automatic read_bins(input bit toggle);
    int   got;
    int   n;
    logic en_prev;
    got     = 0;
    n       = 0;
    en_prev = read_en;
    while (got < hist_pkg::NUM_BINS && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      read_en = toggle ? 1'($urandom_range(1)) : 1'b1;
      @(negedge clk);
      // bin_valid_o follows the read enable of the previous cycle
      assert (!bin_valid || en_prev) else begin
        $display("bin_valid_o rose at %0d ns while read_en_i was low", $time);
        errors++;
      end
      if (bin_valid) begin
        check_value($sformatf("bin_o[%0d]", got), exp_bins[got], bin);
        got++;
      end
      en_prev = read_en;
      n++;
    end
    assert (got == hist_pkg::NUM_BINS) else begin
      $display("timeout: only %0d of the bins arrived", got);
      errors++;
    end
    @(posedge clk);
    #1;
    read_en = 1'b0;
  endtask

  task automatic run_frame(input bit gaps, input bit toggle);
    int n;
    frame_done_cnt = 0;
    read_done_cnt  = 0;
    send_frame(gaps);
    n = 0;
    while (frame_done_cnt == 0 && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    assert (frame_done_cnt != 0) else begin
      $display("timeout: frame_done_o never pulsed after the frame");
      errors++;
    end
    read_bins(toggle);
    n = 0;
    while (read_done_cnt == 0 && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    assert (read_done_cnt != 0) else begin
      $display("timeout: read_done_o never pulsed after the readout");
      errors++;
    end
    check_value("frame_done_o pulses", 1, frame_done_cnt);
    check_value("read_done_o pulses", 1, read_done_cnt);
  endtask

  task automatic finish_test(input string name);
    if (errors == 0) begin
      tests_pass++;
      $display("%s: ok", name);
    end else begin
      tests_fail++;
      $display("%s: FAILED with %0d errors", name, errors);
    end
    errors = 0;
  endtask

  initial begin
    void'($urandom(29188));
    rst_n          = 1'b0;
    pixel          = '0;
    pixel_valid    = 1'b0;
    read_en        = 1'b0;
    errors         = 0;
    tests_pass     = 0;
    tests_fail     = 0;
    frame_done_cnt = 0;
    read_done_cnt  = 0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      check_value("bin_valid_o", 0, bin_valid);
      check_value("frame_done_o", 0, frame_done);
      check_value("read_done_o", 0, read_done);
    end
    finish_test("reset_idle");

    fill_frame(1'b0);
    build_expected();
    run_frame(1'b0, 1'b0);
    finish_test("full_rate_frame");

    fill_frame(1'b0);
    build_expected();
    run_frame(1'b1, 1'b0);
    finish_test("gapped_frame");

    fill_frame(1'b0);
    build_expected();
    run_frame(1'b0, 1'b1);
    finish_test("toggled_readout");

    for (int f = 0; f < 3; f++) begin
      fill_frame(1'b0);
      build_expected();
      run_frame(f == 1, 1'b0);
    end
    finish_test("back_to_back_frames");

    // flat frame lands every window in bin 18
    fill_frame(1'b1);
    for (int b = 0; b < hist_pkg::NUM_BINS; b++) begin
      exp_bins[b] = (b == 18) ? (ROWS - 2) * (COLS - 2) : 0;
    end
    run_frame(1'b0, 1'b0);
    finish_test("flat_frame");

    $display("summary: %0d passing, %0d failing", tests_pass, tests_fail);
    if (tests_fail == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+verification
design/texture_pkg.sv
design/hist_pkg.sv
design/pixel_window.sv
design/riu2_encoder.sv
design/joint_histogram.sv
design/texture_datapath.sv
verification/tb_texture_datapath.sv

/* Bender.yml */
package:
  name: texture_datapath

sources:
  - design/texture_pkg.sv
  - design/hist_pkg.sv
  - design/pixel_window.sv
  - design/riu2_encoder.sv
  - design/joint_histogram.sv
  - design/texture_datapath.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_texture_datapath.sv
